// File: Makefile
VERILATOR ?= verilator
TOP ?= execute_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/execute_tb.sv
`timescale 1ns/100ps

module execute_tb;
  import execute_pkg::*;

  typedef struct packed {
    logic issue_valid;
    logic flush;
    slot_kind_t kind0;
    alu_op_t alu_op0;
    branch_op_t branch_op0;
    div_op_t div_op0;
    reg_addr_t rs1_0;
    reg_addr_t rs2_0;
    reg_addr_t rd0;
    word_t imm0;
    logic use_imm0;
    word_t pc0;
    slot_kind_t kind1;
    alu_op_t alu_op1;
    reg_addr_t rs1_1;
    reg_addr_t rs2_1;
    reg_addr_t rd1;
    word_t imm1;
    logic use_imm1;
    word_t pc1;
  } pair_t;

  typedef struct packed {
    logic [31:0] due;
    logic valid0;
    reg_addr_t rd0;
    logic wren0;
    word_t wdata0;
    logic valid1;
    reg_addr_t rd1;
    logic wren1;
    word_t wdata1;
    logic redirect;
    word_t target;
    logic mem_read;
    logic mem_write;
    word_t mem_address;
    word_t store_data;
    logic exception;
  } expect_t;

  typedef word_t [31:0] reg_copy_t;

  logic clock;
  logic reset;
  logic issue_valid;
  logic flush;
  slot_kind_t kind0;
  alu_op_t alu_op0;
  branch_op_t branch_op0;
  div_op_t div_op0;
  reg_addr_t rs1_0;
  reg_addr_t rs2_0;
  reg_addr_t rd0;
  word_t imm0;
  logic use_imm0;
  word_t pc0;
  slot_kind_t kind1;
  alu_op_t alu_op1;
  reg_addr_t rs1_1;
  reg_addr_t rs2_1;
  reg_addr_t rd1;
  word_t imm1;
  logic use_imm1;
  word_t pc1;
  logic stall;
  logic redirect;
  word_t target;
  logic mem_read;
  logic mem_write;
  word_t mem_address;
  word_t store_data;
  logic exception;
  logic retire_valid0;
  reg_addr_t retire_rd0;
  logic retire_wren0;
  word_t retire_wdata0;
  logic retire_valid1;
  reg_addr_t retire_rd1;
  logic retire_wren1;
  word_t retire_wdata1;

  reg_copy_t model_regs;
  expect_t expect_q [$];
  logic [31:0] cycle;
  integer seed;

  execute_top execute_top_i (.*);

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 32'd1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      add: return a + b;
      sub: return a - b;
      and_op: return a & b;
      or_op: return a | b;
      xor_op: return a ^ b;
      slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      sltu: return (a < b) ? 32'd1 : 32'd0;
      sll: return a << b[4:0];
      srl: return a >> b[4:0];
      sra: return word_t'($signed(a) >>> b[4:0]);
      default: return a + b;
    endcase
  endfunction

  function automatic logic branch_model(input branch_op_t op, input word_t a, input word_t b);
    case (op)
      beq: return a == b;
      bne: return a != b;
      blt: return $signed(a) < $signed(b);
      bge: return $signed(a) >= $signed(b);
      bltu: return a < b;
      bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // RV32M results including the zero divisor and overflow cases
  function automatic word_t divide_model(input div_op_t op, input word_t a, input word_t b);
    logic overflow;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      div: begin
        if (b == '0) return 32'hffff_ffff;
        else if (overflow) return a;
        else return word_t'($signed(a) / $signed(b));
      end
      divu: return (b == '0) ? 32'hffff_ffff : a / b;
      rem: begin
        if (b == '0) return a;
        else if (overflow) return '0;
        else return word_t'($signed(a) % $signed(b));
      end
      default: return (b == '0) ? a : a % b;
    endcase
  endfunction

  function automatic expect_t execute_model(input pair_t p, inout reg_copy_t regs);
    expect_t e;
    word_t a0;
    word_t s2;
    word_t a1;
    word_t b1;
    logic taken;
    e = '0;
    if (!p.issue_valid || p.flush) begin
      return e;
    end
    // both slots read the registers as they were before this pair
    a0 = regs[p.rs1_0];
    s2 = regs[p.rs2_0];
    a1 = regs[p.rs1_1];
    b1 = p.use_imm1 ? p.imm1 : regs[p.rs2_1];
    taken = 1'b0;
    e.valid0 = p.kind0 != nop;
    e.rd0 = p.rd0;
    e.wren0 = p.kind0 inside {alu, lui, auipc, jal, jalr, load, divide};
    e.target = p.pc0 + p.imm0;
    e.mem_address = a0 + p.imm0;
    e.store_data = s2;
    case (p.kind0)
      lui: e.wdata0 = p.imm0;
      auipc: e.wdata0 = p.pc0 + p.imm0;
      jal: begin
        taken = 1'b1;
        e.wdata0 = p.pc0 + 32'd4;
      end
      jalr: begin
        taken = 1'b1;
        e.target = (a0 + p.imm0) & 32'hffff_fffe;
        e.wdata0 = p.pc0 + 32'd4;
      end
      branch: taken = branch_model(p.branch_op0, a0, s2);
      divide: e.wdata0 = divide_model(p.div_op0, a0, s2);
      default: e.wdata0 = alu_model(p.alu_op0, a0, p.use_imm0 ? p.imm0 : s2);
    endcase
    e.exception = (p.kind0 inside {load, store} && e.mem_address[1:0] != 2'b00) ||
                  (taken && e.target[1:0] != 2'b00);
    e.redirect = taken && !e.exception;
    e.mem_read = p.kind0 == load && !e.exception;
    e.mem_write = p.kind0 == store && !e.exception;
    e.wren0 = e.wren0 && !e.exception;
    e.valid1 = p.kind1 == alu && !e.redirect && !e.exception;
    e.rd1 = p.rd1;
    e.wren1 = e.valid1;
    e.wdata1 = alu_model(p.alu_op1, a1, b1);
    if (e.wren0 && p.rd0 != '0) begin
      regs[p.rd0] = e.wdata0;
    end
    if (e.wren1 && p.rd1 != '0) begin
      regs[p.rd1] = e.wdata1;
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      report_failure($sformatf("ERROR: %s expected 0x%h got 0x%h", name, expected, got));
    end
  endtask

  always @(negedge clock) begin : compare_retire
    expect_t e;
    while (expect_q.size() > 0 && expect_q[0].due == cycle) begin
      e = expect_q.pop_front();
      check_value("retire_valid0", 32'(retire_valid0), 32'(e.valid0));
      if (e.valid0) begin
        check_value("retire_rd0", 32'(retire_rd0), 32'(e.rd0));
        check_value("retire_wren0", 32'(retire_wren0), 32'(e.wren0));
      end
      if (e.wren0) begin
        check_value("retire_wdata0", retire_wdata0, e.wdata0);
      end
      check_value("retire_valid1", 32'(retire_valid1), 32'(e.valid1));
      if (e.valid1) begin
        check_value("retire_rd1", 32'(retire_rd1), 32'(e.rd1));
        check_value("retire_wren1", 32'(retire_wren1), 32'(e.wren1));
        check_value("retire_wdata1", retire_wdata1, e.wdata1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  function automatic reg_addr_t pick_source(input reg_addr_t prev0, input reg_addr_t prev1);
    case (rand_below(4))
      0: return prev0;
      1: return prev1;
      2: return '0;
      default: return reg_addr_t'(rand_below(32));
    endcase
  endfunction

  function automatic pair_t idle_pair();
    pair_t p;
    p = '0;
    return p;
  endfunction

  // slot 1 counts up in x10 unless a test overrides it
  function automatic pair_t filled_pair(input word_t pc);
    pair_t p;
    p = '0;
    p.issue_valid = 1'b1;
    p.pc0 = pc;
    p.use_imm0 = 1'b1;
    p.kind1 = alu;
    p.rs1_1 = 5'd10;
    p.rd1 = 5'd10;
    p.imm1 = 32'd1;
    p.use_imm1 = 1'b1;
    p.pc1 = pc + 32'd4;
    return p;
  endfunction

  task automatic drive_pair(input pair_t p);
    issue_valid = p.issue_valid;
    flush = p.flush;
    kind0 = p.kind0;
    alu_op0 = p.alu_op0;
    branch_op0 = p.branch_op0;
    div_op0 = p.div_op0;
    rs1_0 = p.rs1_0;
    rs2_0 = p.rs2_0;
    rd0 = p.rd0;
    imm0 = p.imm0;
    use_imm0 = p.use_imm0;
    pc0 = p.pc0;
    kind1 = p.kind1;
    alu_op1 = p.alu_op1;
    rs1_1 = p.rs1_1;
    rs2_1 = p.rs2_1;
    rd1 = p.rd1;
    imm1 = p.imm1;
    use_imm1 = p.use_imm1;
    pc1 = p.pc1;
  endtask

  // called 10 ns after a rising edge and returns 10 ns after the edge that took the pair
  task automatic issue_pair(input pair_t p);
    expect_t e;
    int waited;
    drive_pair(p);
    e = execute_model(p, model_regs);
    @(negedge clock);
    check_value("stall", 32'(stall), 32'(p.issue_valid && !p.flush && p.kind0 == divide));
    waited = 0;
    while (stall) begin
      if (waited >= 100) begin
        report_failure("stall stayed high for 100 cycles while waiting for the divider");
      end
      @(negedge clock);
      waited++;
    end
    check_value("redirect", 32'(redirect), 32'(e.redirect));
    check_value("exception", 32'(exception), 32'(e.exception));
    check_value("mem_read", 32'(mem_read), 32'(e.mem_read));
    check_value("mem_write", 32'(mem_write), 32'(e.mem_write));
    if (e.redirect) begin
      check_value("target", target, e.target);
    end
    if (e.mem_read || e.mem_write) begin
      check_value("mem_address", mem_address, e.mem_address);
    end
    if (e.mem_write) begin
      check_value("store_data", store_data, e.store_data);
    end
    e.due = cycle + 32'd1;
    expect_q.push_back(e);
    @(posedge clock);
    #10;
  endtask

  task automatic set_regs(input reg_addr_t ra, input word_t va, input reg_addr_t rb,
                          input word_t vb);
    pair_t p;
    p = filled_pair(32'h0000_0040);
    p.kind0 = lui;
    p.rd0 = ra;
    p.imm0 = va;
    p.rs1_1 = '0;
    p.rd1 = rb;
    p.imm1 = vb;
    issue_pair(p);
  endtask

  initial begin : main
    pair_t p;
    reg_addr_t prev0;
    reg_addr_t prev1;
    word_t div_a [8];
    word_t div_b [8];
    int waited;
    clock = 1'b0;
    reset = 1'b0;
    cycle = '0;
    seed = 58;
    model_regs = '0;
    drive_pair(idle_pair());
    repeat (4) @(posedge clock);
    #10;
    reset = 1'b1;

    // control outputs after reset
    @(negedge clock);
    check_value("stall", 32'(stall), 32'd0);
    check_value("redirect", 32'(redirect), 32'd0);
    check_value("mem_read", 32'(mem_read), 32'd0);
    check_value("mem_write", 32'(mem_write), 32'd0);
    check_value("exception", 32'(exception), 32'd0);
    check_value("retire_valid0", 32'(retire_valid0), 32'd0);
    check_value("retire_valid1", 32'(retire_valid1), 32'd0);
    @(posedge clock);
    #10;
    for (int r = 0; r < 16; r++) begin
      p = filled_pair(32'h0000_0100);
      p.kind0 = alu;
      p.use_imm0 = 1'b0;
      p.rs1_0 = reg_addr_t'(2 * r);
      p.rs2_0 = reg_addr_t'(2 * r + 1);
      p.rs1_1 = reg_addr_t'(2 * r + 1);
      p.rs2_1 = reg_addr_t'(2 * r);
      p.use_imm1 = 1'b0;
      p.rd1 = '0;
      issue_pair(p);
    end

    ////////////////////////////////////////////////////////////////////////////
    // back to back random ALU pairs that feed on the previous destinations

    prev0 = '0;
    prev1 = '0;
    for (int i = 0; i < 40; i++) begin
      p = filled_pair(32'h0000_1000);
      p.kind0 = alu;
      p.alu_op0 = alu_op_t'(rand_below(10));
      p.rs1_0 = pick_source(prev0, prev1);
      p.rs2_0 = pick_source(prev0, prev1);
      p.rd0 = reg_addr_t'(rand_below(8));
      p.imm0 = $random(seed);
      p.use_imm0 = rand_below(2) == 1;
      p.alu_op1 = alu_op_t'(rand_below(10));
      p.rs1_1 = pick_source(prev0, prev1);
      p.rs2_1 = pick_source(prev0, prev1);
      p.rd1 = (rand_below(4) == 0) ? p.rd0 : reg_addr_t'(rand_below(8));
      p.imm1 = $random(seed);
      p.use_imm1 = rand_below(2) == 1;
      issue_pair(p);
      prev0 = p.rd0;
      prev1 = p.rd1;
    end

    // branches and jumps
    set_regs(5'd1, 32'd5, 5'd2, 32'hffff_fffd);
    set_regs(5'd3, 32'h0000_1000, 5'd4, 32'h0000_1001);
    for (int op = 0; op < 6; op++) begin
      for (int k = 0; k < 3; k++) begin
        p = filled_pair(32'h0000_0100);
        p.kind0 = branch;
        p.branch_op0 = branch_op_t'(op);
        p.rs1_0 = (k == 2) ? 5'd2 : 5'd1;
        p.rs2_0 = (k == 0) ? 5'd2 : 5'd1;
        p.imm0 = 32'h0000_0040;
        issue_pair(p);
      end
    end
    p = filled_pair(32'h0000_0200);
    p.kind0 = jal;
    p.rd0 = 5'd5;
    p.imm0 = 32'h0000_0080;
    issue_pair(p);
    // the jalr sum is odd so the cleared bit 0 decides the alignment
    p = filled_pair(32'h0000_0210);
    p.kind0 = jalr;
    p.rd0 = 5'd6;
    p.rs1_0 = 5'd4;
    p.imm0 = 32'h0000_0010;
    issue_pair(p);
    p = filled_pair(32'h0000_0220);
    p.kind0 = jal;
    p.rd0 = 5'd5;
    p.imm0 = 32'h0000_0006;
    issue_pair(p);
    p = filled_pair(32'h0000_0230);
    p.kind0 = branch;
    p.rs1_0 = 5'd1;
    p.rs2_0 = 5'd1;
    p.imm0 = 32'h0000_0042;
    issue_pair(p);
    p = filled_pair(32'h0000_0300);
    p.kind0 = auipc;
    p.rd0 = 5'd15;
    p.imm0 = 32'h0000_2000;
    issue_pair(p);

    // loads and stores with the aligned ones first
    p = filled_pair(32'h0000_0400);
    p.kind0 = load;
    p.rd0 = 5'd7;
    p.rs1_0 = 5'd3;
    p.imm0 = 32'h0000_0008;
    issue_pair(p);
    p.kind0 = store;
    p.rs2_0 = 5'd1;
    p.imm0 = 32'hffff_fffc;
    issue_pair(p);
    p.kind0 = load;
    p.imm0 = 32'h0000_0002;
    issue_pair(p);
    p.kind0 = store;
    p.imm0 = 32'h0000_0001;
    issue_pair(p);

    ////////////////////////////////////////////////////////////////////////////
    // divides with four operations per operand pair and no gap between them

    div_a = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c,
              32'd12345, 32'hffff_fffb, 32'h8000_0000, 32'hffff_fff0};
    div_b = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9,
              32'd0, 32'd0, 32'hffff_ffff, 32'd3};
    for (int c = 0; c < 8; c++) begin
      set_regs(5'd8, div_a[c], 5'd9, div_b[c]);
      for (int op = 0; op < 4; op++) begin
        p = filled_pair(32'h0000_0500);
        p.kind0 = divide;
        p.div_op0 = div_op_t'(op);
        p.rs1_0 = 5'd8;
        p.rs2_0 = 5'd9;
        p.rd0 = 5'd11;
        p.rs1_1 = 5'd11;
        issue_pair(p);
      end
    end

    // a flushed pair must not touch the registers
    set_regs(5'd12, 32'h0000_1234, 5'd13, 32'h0000_0055);
    p = filled_pair(32'h0000_0600);
    p.flush = 1'b1;
    p.kind0 = alu;
    p.rd0 = 5'd12;
    p.imm0 = 32'h0000_0999;
    p.rd1 = 5'd13;
    issue_pair(p);
    p = filled_pair(32'h0000_0608);
    p.kind0 = alu;
    p.use_imm0 = 1'b0;
    p.rs1_0 = 5'd12;
    p.rs2_0 = 5'd13;
    p.rd0 = 5'd14;
    p.rs1_1 = 5'd13;
    p.rd1 = 5'd15;
    issue_pair(p);

    drive_pair(idle_pair());
    waited = 0;
    while (expect_q.size() > 0 && waited < 5) begin
      @(posedge clock);
      waited++;
    end
    if (expect_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure("retire records were still pending at the end of the run");
    end
  end

endmodule

// File: common/execute_pkg.sv
package execute_pkg;

  // width of a shift amount in bits
  localparam int XLEN_SHIFT = 5;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // operation encodings

  typedef enum logic [3:0] {
    add, sub, and_op, or_op, xor_op, slt, sltu, sll, srl, sra
  } alu_op_t;

  typedef enum logic [2:0] {
    beq, bne, blt, bge, bltu, bgeu
  } branch_op_t;

  typedef enum logic [1:0] {
    div, divu, rem, remu
  } div_op_t;

  // slot 1 only ever carries nop or alu
  typedef enum logic [3:0] {
    nop, alu, lui, auipc, jal, jalr, branch, load, store, divide
  } slot_kind_t;

  typedef enum logic {
    run, divide_wait
  } stage_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction and result records

  typedef struct packed {
    slot_kind_t kind;
    alu_op_t alu_op;
    branch_op_t branch_op;
    div_op_t div_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t imm;
    logic use_imm;
    word_t pc;
  } decoded_t;

  typedef struct packed {
    logic valid;
    reg_addr_t rd;
    logic wren;
    word_t wdata;
    word_t pc;
  } result_t;

  localparam decoded_t init_decoded = '{
    kind: nop, alu_op: add, branch_op: beq, div_op: div, rs1: '0, rs2: '0, rd: '0,
    imm: '0, use_imm: 1'b0, pc: '0
  };

  localparam result_t init_result = '{valid: 1'b0, rd: '0, wren: 1'b0, wdata: '0, pc: '0};

endpackage

// File: common/forward_if.sv
`timescale 1ns/100ps

interface forward_if;
  import execute_pkg::*;

  logic rden1;
  logic rden2;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  word_t rfdata1;
  word_t rfdata2;
  word_t data1;
  word_t data2;

  modport stage (
    output rden1, rden2, raddr1, raddr2,
    input data1, data2
  );

  modport bypass (
    input rden1, rden2, raddr1, raddr2, rfdata1, rfdata2,
    output data1, data2
  );

endinterface

// File: execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input logic clock,
  input logic reset,
  input logic issue_valid,
  input logic flush,
  input execute_pkg::decoded_t d0,
  input execute_pkg::decoded_t d1,
  forward_if.stage fwd0,
  forward_if.stage fwd1,
  input execute_pkg::word_t alu0_result,
  input execute_pkg::word_t alu1_result,
  input logic agu_taken,
  input execute_pkg::word_t agu_target,
  input execute_pkg::word_t agu_address,
  input logic agu_misaligned,
  input logic div_ready,
  input execute_pkg::word_t div_result,
  output execute_pkg::alu_op_t alu0_op,
  output execute_pkg::word_t alu0_a,
  output execute_pkg::word_t alu0_b,
  output execute_pkg::alu_op_t alu1_op,
  output execute_pkg::word_t alu1_a,
  output execute_pkg::word_t alu1_b,
  output execute_pkg::slot_kind_t agu_kind,
  output execute_pkg::branch_op_t agu_branch_op,
  output execute_pkg::word_t agu_rs1,
  output execute_pkg::word_t agu_rs2,
  output execute_pkg::word_t agu_imm,
  output execute_pkg::word_t agu_pc,
  output logic div_start,
  output execute_pkg::div_op_t div_op,
  output execute_pkg::word_t div_dividend,
  output execute_pkg::word_t div_divisor,
  output execute_pkg::result_t q0,
  output execute_pkg::result_t q1,
  output logic stall,
  output logic redirect,
  output execute_pkg::word_t target,
  output logic mem_read,
  output logic mem_write,
  output execute_pkg::word_t mem_address,
  output execute_pkg::word_t store_data,
  output logic exception
);
  import execute_pkg::*;

  stage_state_t state;
  logic present;
  logic is_divide;
  logic accept;
  logic squash;
  result_t r0;
  result_t r1;

  ////////////////////////////////////////////////////////////////////////////
  // operand fetch and unit inputs

  assign fwd0.rden1 = d0.kind inside {alu, jalr, branch, load, store, divide};
  assign fwd0.rden2 = (d0.kind == alu && !d0.use_imm) || d0.kind inside {branch, store, divide};
  assign fwd0.raddr1 = d0.rs1;
  assign fwd0.raddr2 = d0.rs2;
  assign fwd1.rden1 = d1.kind == alu;
  assign fwd1.rden2 = d1.kind == alu && !d1.use_imm;
  assign fwd1.raddr1 = d1.rs1;
  assign fwd1.raddr2 = d1.rs2;

  assign alu0_op = d0.alu_op;
  assign alu0_a = fwd0.data1;
  assign alu0_b = d0.use_imm ? d0.imm : fwd0.data2;
  assign alu1_op = d1.alu_op;
  assign alu1_a = fwd1.data1;
  assign alu1_b = d1.use_imm ? d1.imm : fwd1.data2;

  assign agu_kind = d0.kind;
  assign agu_branch_op = d0.branch_op;
  assign agu_rs1 = fwd0.data1;
  assign agu_rs2 = fwd0.data2;
  assign agu_imm = d0.imm;
  assign agu_pc = d0.pc;

  assign div_op = d0.div_op;
  assign div_dividend = fwd0.data1;
  assign div_divisor = fwd0.data2;

  ////////////////////////////////////////////////////////////////////////////
  // stall, redirect and memory record

  assign present = issue_valid && !flush;
  assign is_divide = present && d0.kind == divide;
  // in run the divider still shows the old result, so stall without looking at ready
  assign stall = (state == divide_wait) ? !div_ready : is_divide;
  assign div_start = (state == run) && is_divide;
  assign accept = present && !stall;

  assign exception = present && agu_misaligned;
  assign redirect = present && agu_taken && !agu_misaligned;
  assign target = agu_target;
  assign squash = redirect || exception;

  assign mem_read = present && d0.kind == load && !agu_misaligned;
  assign mem_write = present && d0.kind == store && !agu_misaligned;
  assign mem_address = agu_address;
  assign store_data = fwd0.data2;

  always_comb begin
    r0 = init_result;
    r0.valid = d0.kind != nop;
    r0.rd = d0.rd;
    r0.pc = d0.pc;
    r0.wren = d0.kind inside {alu, lui, auipc, jal, jalr, load, divide} && !agu_misaligned;
    case (d0.kind)
      jal, jalr: r0.wdata = d0.pc + 32'd4;
      lui: r0.wdata = d0.imm;
      auipc: r0.wdata = agu_address;
      divide: r0.wdata = div_result;
      default: r0.wdata = alu0_result;
    endcase
    r1 = init_result;
    r1.valid = d1.kind == alu;
    r1.rd = d1.rd;
    r1.pc = d1.pc;
    r1.wren = d1.kind == alu;
    r1.wdata = alu1_result;
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= run;
      q0 <= init_result;
      q1 <= init_result;
    end else begin
      q0 <= accept ? r0 : init_result;
      q1 <= (accept && !squash) ? r1 : init_result;
      case (state)
        run: state <= div_start ? divide_wait : run;
        divide_wait: state <= div_ready ? run : divide_wait;
        default: state <= run;
      endcase
    end
  end

  redirect_squash_check: assert property (@(posedge clock) disable iff (reset == 1'b0)
    redirect |=> !q1.valid);

endmodule

// File: execute/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
  forward_if.bypass fwd,
  input execute_pkg::result_t q0,
  input execute_pkg::result_t q1
);
  import execute_pkg::*;

  // the newer record is checked first, so q1 shadows q0
  function automatic word_t pick(input logic rden, input reg_addr_t addr,
                                 input word_t rfdata, input result_t older,
                                 input result_t newer);
    word_t data;
    data = rfdata;
    if (!rden || addr == '0) begin
      data = '0;
    end else if (newer.valid && newer.wren && newer.rd == addr) begin
      data = newer.wdata;
    end else if (older.valid && older.wren && older.rd == addr) begin
      data = older.wdata;
    end
    return data;
  endfunction

  assign fwd.data1 = pick(fwd.rden1, fwd.raddr1, fwd.rfdata1, q0, q1);
  assign fwd.data2 = pick(fwd.rden2, fwd.raddr2, fwd.rfdata2, q0, q1);

endmodule

// File: filelist.f
common/execute_pkg.sv
common/forward_if.sv
hdl/int_alu.sv
hdl/branch_agu.sv
hdl/serial_divider.sv
hdl/register_file.sv
execute/operand_bypass.sv
execute/execute_stage.sv
hdl/execute_top.sv
bench/execute_tb.sv

// File: hdl/branch_agu.sv
`timescale 1ns/100ps

module branch_agu (
  input execute_pkg::slot_kind_t kind,
  input execute_pkg::branch_op_t branch_op,
  input execute_pkg::word_t rs1_data,
  input execute_pkg::word_t rs2_data,
  input execute_pkg::word_t imm,
  input execute_pkg::word_t pc,
  output logic taken,
  output execute_pkg::word_t target,
  output execute_pkg::word_t address,
  output logic misaligned
);
  import execute_pkg::*;

  logic condition;
  word_t rs1_sum;
  word_t pc_sum;

  assign rs1_sum = rs1_data + imm;
  assign pc_sum = pc + imm;

  always_comb begin
    case (branch_op)
      beq: condition = rs1_data == rs2_data;
      bne: condition = rs1_data != rs2_data;
      blt: condition = $signed(rs1_data) < $signed(rs2_data);
      bge: condition = $signed(rs1_data) >= $signed(rs2_data);
      bltu: condition = rs1_data < rs2_data;
      bgeu: condition = rs1_data >= rs2_data;
      default: condition = 1'b0;
    endcase
  end

  always_comb begin
    taken = (kind == jal) || (kind == jalr) || (kind == branch && condition);
    target = (kind == jalr) ? {rs1_sum[31:1], 1'b0} : pc_sum;
    address = (kind == auipc) ? pc_sum : rs1_sum;
    // word accesses and jump targets both need 4-byte alignment
    misaligned = ((kind == load || kind == store) && address[1:0] != 2'b00) ||
                 (taken && target[1:0] != 2'b00);
  end

endmodule

// File: hdl/execute_top.sv
`timescale 1ns/100ps

module execute_top #(
  parameter int DIV_RADIX_BITS = 1
) (
  input logic clock,
  input logic reset,
  input logic issue_valid,
  input logic flush,
  input execute_pkg::slot_kind_t kind0,
  input execute_pkg::alu_op_t alu_op0,
  input execute_pkg::branch_op_t branch_op0,
  input execute_pkg::div_op_t div_op0,
  input execute_pkg::reg_addr_t rs1_0,
  input execute_pkg::reg_addr_t rs2_0,
  input execute_pkg::reg_addr_t rd0,
  input execute_pkg::word_t imm0,
  input logic use_imm0,
  input execute_pkg::word_t pc0,
  input execute_pkg::slot_kind_t kind1,
  input execute_pkg::alu_op_t alu_op1,
  input execute_pkg::reg_addr_t rs1_1,
  input execute_pkg::reg_addr_t rs2_1,
  input execute_pkg::reg_addr_t rd1,
  input execute_pkg::word_t imm1,
  input logic use_imm1,
  input execute_pkg::word_t pc1,
  output logic stall,
  output logic redirect,
  output execute_pkg::word_t target,
  output logic mem_read,
  output logic mem_write,
  output execute_pkg::word_t mem_address,
  output execute_pkg::word_t store_data,
  output logic exception,
  output logic retire_valid0,
  output execute_pkg::reg_addr_t retire_rd0,
  output logic retire_wren0,
  output execute_pkg::word_t retire_wdata0,
  output logic retire_valid1,
  output execute_pkg::reg_addr_t retire_rd1,
  output logic retire_wren1,
  output execute_pkg::word_t retire_wdata1
);
  import execute_pkg::*;

  decoded_t d0;
  decoded_t d1;
  result_t q0;
  result_t q1;
  reg_addr_t rf_raddr [4];
  word_t rf_rdata [4];
  alu_op_t alu0_op;
  alu_op_t alu1_op;
  word_t alu0_a;
  word_t alu0_b;
  word_t alu1_a;
  word_t alu1_b;
  word_t alu0_result;
  word_t alu1_result;
  slot_kind_t agu_kind;
  branch_op_t agu_branch_op;
  word_t agu_rs1;
  word_t agu_rs2;
  word_t agu_imm;
  word_t agu_pc;
  logic agu_taken;
  word_t agu_target;
  word_t agu_address;
  logic agu_misaligned;
  logic div_start;
  div_op_t div_op;
  word_t div_dividend;
  word_t div_divisor;
  logic div_ready;
  word_t div_result;

  forward_if fwd0 ();
  forward_if fwd1 ();

  always_comb begin
    d0 = init_decoded;
    d0.kind = kind0;
    d0.alu_op = alu_op0;
    d0.branch_op = branch_op0;
    d0.div_op = div_op0;
    d0.rs1 = rs1_0;
    d0.rs2 = rs2_0;
    d0.rd = rd0;
    d0.imm = imm0;
    d0.use_imm = use_imm0;
    d0.pc = pc0;
    // the basic slot keeps the default branch and divide fields
    d1 = init_decoded;
    d1.kind = kind1;
    d1.alu_op = alu_op1;
    d1.rs1 = rs1_1;
    d1.rs2 = rs2_1;
    d1.rd = rd1;
    d1.imm = imm1;
    d1.use_imm = use_imm1;
    d1.pc = pc1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file and bypass

  assign rf_raddr[0] = fwd0.raddr1;
  assign rf_raddr[1] = fwd0.raddr2;
  assign rf_raddr[2] = fwd1.raddr1;
  assign rf_raddr[3] = fwd1.raddr2;
  assign fwd0.rfdata1 = rf_rdata[0];
  assign fwd0.rfdata2 = rf_rdata[1];
  assign fwd1.rfdata1 = rf_rdata[2];
  assign fwd1.rfdata2 = rf_rdata[3];

  register_file register_file_i (
    .clock(clock), .reset(reset), .raddr(rf_raddr),
    .we0(q0.wren), .we1(q1.wren), .waddr0(q0.rd), .waddr1(q1.rd),
    .wdata0(q0.wdata), .wdata1(q1.wdata), .rdata(rf_rdata)
  );

  operand_bypass operand_bypass0_i (.fwd(fwd0), .q0(q0), .q1(q1));
  operand_bypass operand_bypass1_i (.fwd(fwd1), .q0(q0), .q1(q1));

  ////////////////////////////////////////////////////////////////////////////
  // execution units

  int_alu int_alu0_i (.alu_op(alu0_op), .a(alu0_a), .b(alu0_b), .result(alu0_result));
  int_alu int_alu1_i (.alu_op(alu1_op), .a(alu1_a), .b(alu1_b), .result(alu1_result));

  branch_agu branch_agu_i (
    .kind(agu_kind), .branch_op(agu_branch_op), .rs1_data(agu_rs1), .rs2_data(agu_rs2),
    .imm(agu_imm), .pc(agu_pc), .taken(agu_taken), .target(agu_target),
    .address(agu_address), .misaligned(agu_misaligned)
  );

  serial_divider #(.DIV_RADIX_BITS(DIV_RADIX_BITS)) serial_divider_i (
    .clock(clock), .reset(reset), .start(div_start), .div_op(div_op),
    .dividend(div_dividend), .divisor(div_divisor), .ready(div_ready),
    .quotient_or_rem(div_result)
  );

  execute_stage execute_stage_i (.*);

  assign retire_valid0 = q0.valid;
  assign retire_rd0 = q0.rd;
  assign retire_wren0 = q0.wren;
  assign retire_wdata0 = q0.wdata;
  assign retire_valid1 = q1.valid;
  assign retire_rd1 = q1.rd;
  assign retire_wren1 = q1.wren;
  assign retire_wdata1 = q1.wdata;

endmodule

// File: hdl/int_alu.sv
`timescale 1ns/100ps

module int_alu (
  input execute_pkg::alu_op_t alu_op,
  input execute_pkg::word_t a,
  input execute_pkg::word_t b,
  output execute_pkg::word_t result
);
  import execute_pkg::*;

  logic [XLEN_SHIFT-1:0] shamt;

  // shifts only look at the low bits of the second operand
  assign shamt = b[XLEN_SHIFT-1:0];

  always_comb begin
    case (alu_op)
      add: result = a + b;
      sub: result = a - b;
      and_op: result = a & b;
      or_op: result = a | b;
      xor_op: result = a ^ b;
      slt: result = {31'b0, $signed(a) < $signed(b)};
      sltu: result = {31'b0, a < b};
      sll: result = a << shamt;
      srl: result = a >> shamt;
      sra: result = $signed(a) >>> shamt;
      default: result = a + b;
    endcase
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/100ps

module register_file (
  input logic clock,
  input logic reset,
  input execute_pkg::reg_addr_t raddr [4],
  input logic we0,
  input logic we1,
  input execute_pkg::reg_addr_t waddr0,
  input execute_pkg::reg_addr_t waddr1,
  input execute_pkg::word_t wdata0,
  input execute_pkg::word_t wdata1,
  output execute_pkg::word_t rdata [4]
);
  import execute_pkg::*;

  word_t regs [32];

  // slot 1 is written last so it wins on a shared destination
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && waddr0 != '0) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
    end
  end

endmodule

// File: hdl/serial_divider.sv
`timescale 1ns/100ps

module serial_divider #(
  parameter int DIV_RADIX_BITS = 1
) (
  input logic clock,
  input logic reset,
  input logic start,
  input execute_pkg::div_op_t div_op,
  input execute_pkg::word_t dividend,
  input execute_pkg::word_t divisor,
  output logic ready,
  output execute_pkg::word_t quotient_or_rem
);
  import execute_pkg::*;

  localparam int STEPS = 32 / DIV_RADIX_BITS;

  logic busy;
  logic [5:0] count;
  word_t rem_q;
  word_t quo_q;
  word_t div_mag;
  logic want_rem;
  logic neg_quo;
  logic neg_rem;
  word_t rem_next;
  word_t quo_next;
  logic is_signed;
  logic dividend_neg;
  logic divisor_neg;

  assign is_signed = (div_op == div) || (div_op == rem);
  assign dividend_neg = is_signed && dividend[31];
  assign divisor_neg = is_signed && divisor[31];
  assign ready = !busy;

  // one cycle runs DIV_RADIX_BITS restoring steps
  // the quotient register doubles as the dividend shifter
  always_comb begin
    logic [32:0] shifted;
    logic [33:0] diff;
    rem_next = rem_q;
    quo_next = quo_q;
    for (int i = 0; i < DIV_RADIX_BITS; i++) begin
      shifted = {rem_next, quo_next[31]};
      diff = {1'b0, shifted} - {2'b00, div_mag};
      quo_next = {quo_next[30:0], ~diff[33]};
      rem_next = diff[33] ? shifted[31:0] : diff[31:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      busy <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      count <= 6'(STEPS);
    end else if (busy) begin
      busy <= (count != 6'd1);
      count <= count - 6'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      rem_q <= '0;
      quo_q <= dividend_neg ? -dividend : dividend;
      div_mag <= divisor_neg ? -divisor : divisor;
      want_rem <= (div_op == rem) || (div_op == remu);
      // a zero divisor keeps the all-ones quotient whatever the signs
      neg_quo <= (dividend_neg ^ divisor_neg) && (divisor != '0);
      neg_rem <= dividend_neg;
    end else if (busy) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

  always_comb begin
    if (want_rem) begin
      quotient_or_rem = neg_rem ? -rem_q : rem_q;
    end else begin
      quotient_or_rem = neg_quo ? -quo_q : quo_q;
    end
  end

  start_idle_check: assert property (@(posedge clock) disable iff (reset == 1'b0)
    start |-> !busy);

  ready_reset_check: assert property (@(posedge clock) $rose(reset) |-> ready);

endmodule
